/* verilog/cpu_frontend_pkg.sv */
`default_nettype none

/*
 * CPU front end shared definitions
 * Widths, opcode encodings, bubble value and vector handshake states
 */
package cpu_frontend_pkg;

    //////////////////////////////////////////////////////////////////////
    // Datapath widths
    //////////////////////////////////////////////////////////////////////

    // Instruction word and address width
    localparam int WORD_W = 16;

    // Instruction memory geometry
    localparam int ROM_DEPTH = 256;
    localparam int ROM_AW = $clog2(ROM_DEPTH);

    //////////////////////////////////////////////////////////////////////
    // Instruction format
    //////////////////////////////////////////////////////////////////////

    // Opcode lives in the top five bits, 15 to 11
    localparam int OPC_W = 5;
    localparam int OPC_LSB = 11;

    // Signed jump offset in the low bits
    localparam int JMP_OFS_W = 11;

    // Vector command payload in the low bits
    localparam int VEC_CMD_W = 11;

    //////////////////////////////////////////////////////////////////////
    // Opcodes
    //////////////////////////////////////////////////////////////////////

    // No operation, never issued
    localparam logic [OPC_W-1:0] OPC_NOP = 5'h0F;

    // Unconditional jump, target is PC+1 plus offset
    localparam logic [OPC_W-1:0] OPC_JMP = 5'h10;

    // Vector unit command
    localparam logic [OPC_W-1:0] OPC_VEC = 5'h18;

    // Bubble word for reset and flush
    localparam logic [WORD_W-1:0] NOP_INSTR = 16'h7800;

    //////////////////////////////////////////////////////////////////////
    // Vector handshake
    //////////////////////////////////////////////////////////////////////

    // Four-phase req/ack sequencing
    typedef enum logic [1:0] {
        VEC_IDLE,   // no command outstanding
        VEC_REQ,    // req high, waiting for ack
        VEC_REL     // req dropped, waiting for ack to fall
    } vec_state_t;

endpackage

`default_nettype wire

/* verilog/fetch_if.sv */
`timescale 1ns/100ps
`default_nettype none

/*
 * Fetch to decode link
 * Instruction and PC+1 forward, redirect and freeze back
 */
interface fetch_if import cpu_frontend_pkg::*; ();

    // Forward path, IF pipeline register contents
    logic [WORD_W-1:0] instr;
    logic [WORD_W-1:0] pc_plus_one;

    // Backward path from decode
    logic              pc_select;
    logic [WORD_W-1:0] pc_target;
    logic              freeze;

    modport fetch (
        output instr,
        output pc_plus_one,
        input  pc_select,
        input  pc_target,
        input  freeze
    );

    modport decode (
        input  instr,
        input  pc_plus_one,
        output pc_select,
        output pc_target,
        output freeze
    );

endinterface

`default_nettype wire

/* verilog/instr_rom.sv */
`timescale 1ns/100ps
`default_nettype none

/*
 * Instruction memory
 * Word array with a synchronous load port and same-cycle read
 */
module instr_rom import cpu_frontend_pkg::*; (
    input  logic              clk,
    input  logic              we,
    input  logic [ROM_AW-1:0] waddr,
    input  logic [WORD_W-1:0] wdata,
    input  logic [ROM_AW-1:0] raddr,
    output logic [WORD_W-1:0] rdata
);

    // Program storage
    logic [WORD_W-1:0] mem [ROM_DEPTH];

    //////////////////////////////////////////////////////////////////////
    // Load port
    //////////////////////////////////////////////////////////////////////

    // Written while the core sits in reset
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Fetch port
    //////////////////////////////////////////////////////////////////////

    // Combinational read, data valid in the PC cycle
    assign rdata = mem[raddr];

endmodule

`default_nettype wire

/* verilog/instr_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

/*
 * Instruction fetch stage
 * PC register, next-PC select and the IF pipeline register
 */
module instr_fetch import cpu_frontend_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    fetch_if.fetch            fif,
    output logic [ROM_AW-1:0] rom_addr,
    input  logic [WORD_W-1:0] rom_data
);

    logic [WORD_W-1:0] pc;
    logic [WORD_W-1:0] pc_inc;
    logic [WORD_W-1:0] pc_next;

    //////////////////////////////////////////////////////////////////////
    // Program counter
    //////////////////////////////////////////////////////////////////////

    // PC+1 adder
    assign pc_inc = pc + WORD_W'(1);

    // Redirect wins over sequential flow
    assign pc_next = fif.pc_select ? fif.pc_target : pc_inc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (fif.pc_select) begin
            // Jump taken even under stall
            pc <= pc_next;
        end else if (!stall && !fif.freeze) begin
            pc <= pc_next;
        end
    end

    // Word address into instruction memory
    assign rom_addr = pc[ROM_AW-1:0];

    //////////////////////////////////////////////////////////////////////
    // IF pipeline register
    //////////////////////////////////////////////////////////////////////

    // Bubble into the instruction word on freeze or redirect
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fif.instr <= NOP_INSTR;
        end else if (fif.freeze || fif.pc_select) begin
            fif.instr <= NOP_INSTR;
        end else if (!stall) begin
            fif.instr <= rom_data;
        end
    end

    // Address of the fetched word plus one
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fif.pc_plus_one <= '0;
        end else if (!stall) begin
            fif.pc_plus_one <= pc_inc;
        end
    end

endmodule

`default_nettype wire

/* verilog/decode_branch.sv */
`timescale 1ns/100ps
`default_nettype none

/*
 * Decode and branch stage
 * Resolves jumps, drives the vector req/ack handshake
 * and registers ordinary instructions onto the issue port
 */
module decode_branch import cpu_frontend_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,
    fetch_if.decode              fif,
    output logic                 vec_req,
    output logic [VEC_CMD_W-1:0] vec_cmd,
    input  logic                 vec_ack,
    output logic                 issue_valid,
    output logic [WORD_W-1:0]    issue_instr,
    output logic [WORD_W-1:0]    issue_pc
);

    logic [OPC_W-1:0]     opc;
    logic                 is_jmp;
    logic                 is_vec;
    logic                 is_ordinary;
    logic                 vec_start;
    logic [WORD_W-1:0]    jmp_ofs;
    vec_state_t           vec_state;
    vec_state_t           vec_state_d;
    logic [VEC_CMD_W-1:0] vec_cmd_q;

    //////////////////////////////////////////////////////////////////////
    // Opcode classification
    //////////////////////////////////////////////////////////////////////

    assign opc = fif.instr[OPC_LSB +: OPC_W];

    assign is_jmp = (opc == OPC_JMP);
    assign is_vec = (opc == OPC_VEC);

    // Anything else except NOP goes to the back end
    assign is_ordinary = !is_jmp && !is_vec && (opc != OPC_NOP);

    //////////////////////////////////////////////////////////////////////
    // Jump redirect
    //////////////////////////////////////////////////////////////////////

    // Sign-extend the 11-bit offset
    assign jmp_ofs = {{(WORD_W-JMP_OFS_W){fif.instr[JMP_OFS_W-1]}},
                      fif.instr[JMP_OFS_W-1:0]};

    // Target relative to the word after the jump
    assign fif.pc_target = fif.pc_plus_one + jmp_ofs;

    // Same-cycle redirect, fetch flushes the word behind us
    assign fif.pc_select = is_jmp && !stall;

    //////////////////////////////////////////////////////////////////////
    // Vector handshake
    //////////////////////////////////////////////////////////////////////

    // New command accepted only from idle
    assign vec_start = is_vec && !stall && (vec_state == VEC_IDLE);

    always_comb begin
        vec_state_d = vec_state;
        case (vec_state)
            VEC_IDLE: begin
                if (vec_start) begin
                    vec_state_d = VEC_REQ;
                end
            end
            VEC_REQ: begin
                // Phase 2 seen, drop req
                if (vec_ack) begin
                    vec_state_d = VEC_REL;
                end
            end
            VEC_REL: begin
                // Phase 4 seen, handshake closed
                if (!vec_ack) begin
                    vec_state_d = VEC_IDLE;
                end
            end
            default: begin
                vec_state_d = VEC_IDLE;
            end
        endcase
    end

    // Keeps running under stall
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vec_state <= VEC_IDLE;
        end else begin
            vec_state <= vec_state_d;
        end
    end

    // Command captured with the request
    always_ff @(posedge clk) begin
        if (vec_start) begin
            vec_cmd_q <= fif.instr[VEC_CMD_W-1:0];
        end
    end

    assign vec_req = (vec_state == VEC_REQ);
    assign vec_cmd = vec_cmd_q;

    // Hold fetch from the VEC until ack has fallen
    assign fif.freeze = vec_start || (vec_state != VEC_IDLE);

    //////////////////////////////////////////////////////////////////////
    // Issue port
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= is_ordinary && !stall;
        end
    end

    // Payload, address recovered from PC+1
    always_ff @(posedge clk) begin
        if (is_ordinary && !stall) begin
            issue_instr <= fif.instr;
            issue_pc    <= fif.pc_plus_one - WORD_W'(1);
        end
    end

endmodule

`default_nettype wire

/* verilog/cpu_frontend.sv */
`timescale 1ns/100ps
`default_nettype none

/*
 * CPU front end top level
 * Instruction memory, fetch and decode behind plain ports
 */
module cpu_frontend import cpu_frontend_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,

    // Program load port
    input  logic                 prog_we,
    input  logic [ROM_AW-1:0]    prog_addr,
    input  logic [WORD_W-1:0]    prog_data,

    // Vector unit, four-phase
    output logic                 vec_req,
    output logic [VEC_CMD_W-1:0] vec_cmd,
    input  logic                 vec_ack,

    // Issue stream to the back end
    output logic                 issue_valid,
    output logic [WORD_W-1:0]    issue_instr,
    output logic [WORD_W-1:0]    issue_pc
);

    // Fetch to memory
    logic [ROM_AW-1:0] rom_addr;
    logic [WORD_W-1:0] rom_data;

    // Fetch to decode
    fetch_if fif ();

    //////////////////////////////////////////////////////////////////////
    // Instruction memory
    //////////////////////////////////////////////////////////////////////

    instr_rom u_rom (
        .clk   (clk),
        .we    (prog_we),
        .waddr (prog_addr),
        .wdata (prog_data),
        .raddr (rom_addr),
        .rdata (rom_data)
    );

    //////////////////////////////////////////////////////////////////////
    // Pipeline stages
    //////////////////////////////////////////////////////////////////////

    instr_fetch u_fetch (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .fif      (fif.fetch),
        .rom_addr (rom_addr),
        .rom_data (rom_data)
    );

    decode_branch u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .fif         (fif.decode),
        .vec_req     (vec_req),
        .vec_cmd     (vec_cmd),
        .vec_ack     (vec_ack),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .issue_pc    (issue_pc)
    );

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

/*
 * Testbench clock source, 4 ns period
 */
module tb_clock (
    output logic clk
);

    // Half of the 4 ns period
    localparam int HALF_NS = 2;

    initial begin
        clk = 1'b0;
    end

    always #HALF_NS clk = ~clk;

endmodule

`default_nettype wire

/* sim/cpu_frontend_props.sv */
`timescale 1ns/100ps
`default_nettype none

/*
 * Vector handshake and fetch freeze checks
 * Bound into the decode stage
 */
module cpu_frontend_props import cpu_frontend_pkg::*; (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 vec_req,
    input logic                 vec_ack,
    input logic [VEC_CMD_W-1:0] vec_cmd,
    input logic                 freeze
);

    // Phase 1 holds until phase 2
    req_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
        (vec_req && !vec_ack) |=> vec_req)
        else $error("vec_req fell before vec_ack rose");

    // No new request until phase 4
    no_req_while_ack: assert property (@(posedge clk) disable iff (!rst_n)
        (!vec_req && vec_ack) |=> !vec_req)
        else $error("vec_req rose again while vec_ack was high");

    // Command payload steady across the request
    cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
        vec_req |=> $stable(vec_cmd))
        else $error("vec_cmd changed while vec_req was high");

    // Fetch held for the whole exchange
    freeze_held: assert property (@(posedge clk) disable iff (!rst_n)
        (vec_req || vec_ack) |-> freeze)
        else $error("freeze low during the vector handshake");

endmodule

bind decode_branch cpu_frontend_props u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .vec_req (vec_req),
    .vec_ack (vec_ack),
    .vec_cmd (vec_cmd),
    .freeze  (fif.freeze)
);

`default_nettype wire

/* sim/tb_cpu_frontend.sv */
`timescale 1ns/100ps
`default_nettype none

/*
 * CPU front end testbench
 * Directed programs checked against a fetch and decode program model
 */
module tb_cpu_frontend import cpu_frontend_pkg::*; ();

    //////////////////////////////////////////////////////////////////////
    // Run limits
    //////////////////////////////////////////////////////////////////////

    localparam int CLK_NS       = 4;
    localparam int RESET_CYCLES = 16;
    // One program word written per reset cycle
    localparam int PROG_MAX     = 16;
    localparam int PROG_AW      = 4;
    localparam int DRAIN_CYCLES = 12;
    localparam int RUNS         = 6;
    // Random stall plus two ack delays per word rounded up
    localparam int WORD_COST    = 48;
    localparam int LIMIT_CYCLES = RUNS * (RESET_CYCLES + DRAIN_CYCLES + 4 + PROG_MAX * WORD_COST);
    localparam logic [31:0] SEED = 32'hc3c1_5d6f;

    // Self jump with offset -1 ends every program
    localparam logic [WORD_W-1:0] HALT = {OPC_JMP, 11'h7FF};

    // Vector responder phases
    localparam int R_IDLE = 0;
    localparam int R_ACK  = 1;
    localparam int R_DROP = 2;
    localparam int R_REL  = 3;

    logic                 clk;
    logic                 rst_n = 1'b0;
    logic                 stall = 1'b0;
    logic                 prog_we = 1'b0;
    logic [ROM_AW-1:0]    prog_addr = '0;
    logic [WORD_W-1:0]    prog_data = '0;
    logic                 vec_req;
    logic [VEC_CMD_W-1:0] vec_cmd;
    logic                 vec_ack = 1'b0;
    logic                 issue_valid;
    logic [WORD_W-1:0]    issue_instr;
    logic [WORD_W-1:0]    issue_pc;

    // Program image and the expected streams
    logic [WORD_W-1:0]    prog_mem [PROG_MAX];
    logic [WORD_W-1:0]    exp_instr [$];
    logic [WORD_W-1:0]    exp_pc [$];
    logic [VEC_CMD_W-1:0] exp_vec [$];

    int          issue_idx = 0;
    int          vec_idx = 0;
    int          resp_state = R_IDLE;
    logic [2:0]  resp_delay = '0;
    logic [31:0] stall_lfsr = SEED;
    logic [31:0] resp_lfsr = SEED;
    logic        stall_random = 1'b0;
    logic        stall_prev = 1'b0;

    tb_clock u_clock (.clk (clk));

    cpu_frontend u_cpu_frontend (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .prog_we     (prog_we),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .vec_req     (vec_req),
        .vec_cmd     (vec_cmd),
        .vec_ack     (vec_ack),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .issue_pc    (issue_pc)
    );

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [WORD_W-1:0] got,
                               input logic [WORD_W-1:0] exp);
        if (got !== exp) begin
            $display("Error: %0t: %s = %h, expected %h", $time, name, got, exp);
            abort_run("Stopping at the first mismatch");
        end
    endtask

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic lfsr_step(inout logic [31:0] state);
        logic fb;
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];
        state = {state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [2:0] lfsr_delay(inout logic [31:0] state);
        logic [2:0] v;
        v = '0;
        for (int i = 0; i < 3; i++) begin
            v = {v[1:0], lfsr_step(state)};
        end
        return v;
    endfunction

    function automatic logic [WORD_W-1:0] encode_word(input logic [OPC_W-1:0] opc,
                                                      input logic [10:0] low);
        return {opc, low};
    endfunction

    // Unreached filler carrying its address in the payload
    task automatic clear_prog();
        for (int i = 0; i < PROG_MAX; i++) begin
            prog_mem[PROG_AW'(i)] = encode_word(5'h03, 11'(i));
        end
    endtask

    // Walk the image from address 0 as fetch and decode would
    task automatic build_model();
        int                pc;
        int                steps;
        logic [WORD_W-1:0] word;
        logic [OPC_W-1:0]  opc;
        logic              halted;
        exp_instr.delete();
        exp_pc.delete();
        exp_vec.delete();
        pc = 0;
        steps = 0;
        halted = 1'b0;
        while (!halted) begin
            if (pc < 0 || pc >= PROG_MAX || steps > 4 * PROG_MAX) begin
                abort_run("Program model left the program image");
            end
            word = prog_mem[PROG_AW'(pc)];
            opc = word[OPC_LSB +: OPC_W];
            steps++;
            if (opc == OPC_JMP) begin
                if (word == HALT) begin
                    halted = 1'b1;
                end else begin
                    // Relative to the word after the jump
                    pc = pc + 1 + int'($signed(word[10:0]));
                end
            end else if (opc == OPC_VEC) begin
                exp_vec.push_back(word[VEC_CMD_W-1:0]);
                pc++;
            end else begin
                if (opc != OPC_NOP) begin
                    exp_instr.push_back(word);
                    exp_pc.push_back(WORD_W'(pc));
                end
                pc++;
            end
        end
    endtask

    task automatic reset_and_load();
        @(posedge clk);
        rst_n <= 1'b0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            prog_we   <= 1'b1;
            prog_addr <= ROM_AW'(i);
            prog_data <= prog_mem[PROG_AW'(i)];
            @(posedge clk);
        end
        prog_we <= 1'b0;
        check_value("issue_valid", WORD_W'(issue_valid), '0);
        check_value("vec_req", WORD_W'(vec_req), '0);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        check_value("issue_valid", WORD_W'(issue_valid), '0);
        check_value("vec_req", WORD_W'(vec_req), '0);
    endtask

    task automatic run_program(input logic with_stall);
        build_model();
        reset_and_load();
        stall_random <= with_stall;
        // Done once every issue and every vector exchange is seen
        while (issue_idx < exp_instr.size() || vec_idx < exp_vec.size()
               || resp_state != R_IDLE) begin
            @(posedge clk);
        end
        stall_random <= 1'b0;
        repeat (DRAIN_CYCLES) @(posedge clk);
        check_value("vec_req", WORD_W'(vec_req), '0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Program images
    //////////////////////////////////////////////////////////////////////

    task automatic straight_line_image();
        clear_prog();
        prog_mem[0]  = encode_word(5'h01, 11'h001);
        prog_mem[1]  = encode_word(5'h02, 11'h123);
        prog_mem[2]  = NOP_INSTR;
        prog_mem[3]  = encode_word(5'h04, 11'h7FF);
        prog_mem[4]  = encode_word(5'h1F, 11'h0AA);
        prog_mem[5]  = encode_word(5'h00, 11'h000);
        prog_mem[6]  = encode_word(OPC_NOP, 11'h055);
        prog_mem[7]  = encode_word(5'h08, 11'h3C3);
        // Opcodes next to JMP and VEC are ordinary
        prog_mem[8]  = encode_word(5'h11, 11'h222);
        prog_mem[9]  = encode_word(5'h19, 11'h111);
        prog_mem[10] = encode_word(5'h0E, 11'h456);
        prog_mem[11] = HALT;
    endtask

    task automatic vector_image();
        clear_prog();
        prog_mem[0] = encode_word(5'h01, 11'h010);
        prog_mem[1] = encode_word(OPC_VEC, 11'h123);
        prog_mem[2] = encode_word(5'h02, 11'h020);
        // Back to back commands
        prog_mem[3] = encode_word(OPC_VEC, 11'h5A5);
        prog_mem[4] = encode_word(OPC_VEC, 11'h00F);
        prog_mem[5] = encode_word(5'h04, 11'h040);
        prog_mem[6] = NOP_INSTR;
        prog_mem[7] = encode_word(5'h08, 11'h080);
        prog_mem[8] = HALT;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic straight_line_test();
        straight_line_image();
        run_program(1'b0);
    endtask

    // Jumps forward to 5, back to 3 and forward to 7 so word 2 is never issued
    task automatic jump_test();
        clear_prog();
        prog_mem[0] = encode_word(5'h01, 11'h0A0);
        prog_mem[1] = encode_word(OPC_JMP, 11'h003);
        prog_mem[2] = encode_word(5'h0B, 11'h0BD);
        prog_mem[3] = encode_word(5'h02, 11'h0B0);
        prog_mem[4] = encode_word(OPC_JMP, 11'h002);
        prog_mem[5] = encode_word(5'h05, 11'h0C0);
        prog_mem[6] = encode_word(OPC_JMP, 11'h7FC);
        prog_mem[7] = encode_word(5'h07, 11'h0D0);
        prog_mem[8] = HALT;
        run_program(1'b0);
    endtask

    task automatic vector_test();
        vector_image();
        run_program(1'b0);
    endtask

    task automatic stall_test();
        straight_line_image();
        run_program(1'b1);
        vector_image();
        run_program(1'b1);
    endtask

    // Fresh program under a new reset starting with a vector
    task automatic restart_test();
        clear_prog();
        prog_mem[0]  = encode_word(OPC_VEC, 11'h7FF);
        prog_mem[1]  = encode_word(OPC_JMP, 11'h002);
        prog_mem[2]  = encode_word(5'h01, 11'h0EE);
        prog_mem[3]  = encode_word(5'h01, 11'h0EF);
        prog_mem[4]  = encode_word(5'h05, 11'h444);
        prog_mem[5]  = encode_word(OPC_VEC, 11'h2AB);
        prog_mem[6]  = encode_word(5'h06, 11'h666);
        prog_mem[7]  = encode_word(OPC_JMP, 11'h001);
        prog_mem[8]  = encode_word(5'h01, 11'h0F0);
        prog_mem[9]  = encode_word(5'h07, 11'h777);
        prog_mem[10] = HALT;
        run_program(1'b0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus, responder and monitor
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (stall_random) begin
            stall <= lfsr_step(stall_lfsr);
        end else begin
            stall <= 1'b0;
        end
    end

    // Vector unit model with random ack delays
    always @(posedge clk) begin
        if (!rst_n) begin
            resp_state <= R_IDLE;
            vec_ack    <= 1'b0;
            vec_idx    <= 0;
        end else begin
            case (resp_state)
                R_IDLE: begin
                    if (vec_req && vec_idx >= exp_vec.size()) begin
                        abort_run("Vector request with no VEC left in the program");
                    end else if (vec_req) begin
                        check_value("vec_cmd", WORD_W'(vec_cmd), WORD_W'(exp_vec[vec_idx]));
                        vec_idx    <= vec_idx + 1;
                        resp_delay <= lfsr_delay(resp_lfsr);
                        resp_state <= R_ACK;
                    end
                end
                R_ACK: begin
                    check_value("vec_req", WORD_W'(vec_req), WORD_W'(1'b1));
                    if (resp_delay == '0) begin
                        vec_ack    <= 1'b1;
                        resp_state <= R_DROP;
                    end else begin
                        resp_delay <= resp_delay - 3'd1;
                    end
                end
                R_DROP: begin
                    if (!vec_req) begin
                        resp_delay <= lfsr_delay(resp_lfsr);
                        resp_state <= R_REL;
                    end
                end
                default: begin
                    check_value("vec_req", WORD_W'(vec_req), '0);
                    if (resp_delay == '0) begin
                        vec_ack    <= 1'b0;
                        resp_state <= R_IDLE;
                    end else begin
                        resp_delay <= resp_delay - 3'd1;
                    end
                end
            endcase
        end
    end

    // Issue stream checked in order against the model
    always @(posedge clk) begin
        stall_prev <= stall;
        if (!rst_n) begin
            issue_idx <= 0;
        end else begin
            if (stall_prev) begin
                check_value("issue_valid", WORD_W'(issue_valid), '0);
            end
            if (issue_valid && (vec_req || vec_ack)) begin
                abort_run("Instruction issued during a vector handshake");
            end else if (issue_valid && issue_idx >= exp_instr.size()) begin
                abort_run("Issue beyond the end of the expected sequence");
            end else if (issue_valid) begin
                check_value("issue_instr", issue_instr, exp_instr[issue_idx]);
                check_value("issue_pc", issue_pc, exp_pc[issue_idx]);
                issue_idx <= issue_idx + 1;
            end
        end
    end

    initial begin
        #(LIMIT_CYCLES * CLK_NS);
        abort_run("Watchdog expired before the tests finished");
    end

    initial begin
        $timeformat(-9, 1, " ns", 0);
        straight_line_test();
        jump_test();
        vector_test();
        stall_test();
        restart_test();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
verilog/cpu_frontend_pkg.sv
verilog/fetch_if.sv
verilog/instr_rom.sv
verilog/instr_fetch.sv
verilog/decode_branch.sv
verilog/cpu_frontend.sv
sim/tb_clock.sv
sim/cpu_frontend_props.sv
sim/tb_cpu_frontend.sv

/* Makefile */
# Verilator simulation of the CPU front end

VERILATOR ?= verilator
TOP       ?= tb_cpu_frontend
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= SIMULATION PASSED

.PHONY: sim clean

# Pass only when the testbench prints its pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
